// ==== logic/dvc_pkg.sv ====
`default_nettype none

package dvc_pkg;

    localparam int WORD_W = 16;    // CPU data bus
    localparam int ADDR_W = 23;    // Word address, A23..A1
    localparam int REG_W  = 15;    // Decoded register index

    // FMA (audio) register word addresses
    localparam logic [REG_W-1:0] FMA_CMD    = 15'h1800;
    localparam logic [REG_W-1:0] FMA_IVEC   = 15'h1806;
    localparam logic [REG_W-1:0] FMA_DCLKH  = 15'h1808;
    localparam logic [REG_W-1:0] FMA_DCLKL  = 15'h1809;
    localparam logic [REG_W-1:0] FMA_ISR    = 15'h180D;
    localparam logic [REG_W-1:0] FMA_IER    = 15'h180E;

    // FMV (video) register word addresses
    localparam logic [REG_W-1:0] FMV_IER    = 15'h2030;
    localparam logic [REG_W-1:0] FMV_ISR    = 15'h2031;
    localparam logic [REG_W-1:0] FMV_TCNT   = 15'h2032;
    localparam logic [REG_W-1:0] FMV_TRLD   = 15'h2057;
    localparam logic [REG_W-1:0] FMV_SYSCMD = 15'h2060;
    localparam logic [REG_W-1:0] FMV_IVEC   = 15'h206E;
    localparam logic [REG_W-1:0] FMV_XFER   = 15'h206F;

    localparam int FMA_POLL_BIT = 8;     // Poll flag in FMA ISR/IER
    localparam int FMA_DMA_BIT  = 15;    // DMA start in FMA_CMD
    localparam logic [WORD_W-1:0] FMV_DMA_START = 16'h8000;

    localparam int TIMER_FRAC = 3;       // 8 DCLK ticks per compare step
    localparam int DCLK_W     = 32;

    // FMV interrupt flags, MSB first
    typedef struct packed {
        logic erdv;
        logic erdd;
        logic vcup;
        logic pai;
        logic vsync;    // Vertical sync edge
        logic eii;
        logic esi;
        logic tim;      // Interval timer match
        logic dcl;
        logic ovf;
        logic ndat;
        logic rfb;
        logic eod;
        logic pic;
        logic gop;
        logic seq;
    } fmv_flags_s;

    // Set flag by flag, read and masked as a whole word
    typedef union packed {
        fmv_flags_s               flags;
        logic [WORD_W-1:0]        raw;
    } fmv_isr_u;

endpackage

`default_nettype wire

// ==== logic/dvc_bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module dvc_bus_decoder #(
    parameter int RAM_EN_WRITES = 64
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cs,
    input  logic                             uds,
    input  logic                             lds,
    input  logic                             write_strobe,
    input  logic [dvc_pkg::ADDR_W-1:0]       address,
    input  logic [dvc_pkg::WORD_W-1:0]       din,
    output logic                             bus_ack,
    output logic                             reg_rd,
    output logic                             reg_wr,
    output logic                             mpeg_ram_enabled,
    output logic [dvc_pkg::REG_W-1:0]        reg_addr,
    output logic [dvc_pkg::WORD_W-1:0]       wr_data
);

    localparam int CNT_W = $clog2(RAM_EN_WRITES);

    logic             access;
    logic [CNT_W-1:0] wr_cnt;

    assign access = cs && (uds || lds);

    // Second edge of an access completes the cycle
    assign reg_wr   = access && bus_ack && write_strobe;
    assign reg_rd   = access && bus_ack && !write_strobe;
    assign reg_addr = address[dvc_pkg::REG_W-1:0];    // Low word address bits select the register
    assign wr_data  = din;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack <= 1'b0;
        end else begin
            bus_ack <= access ? !bus_ack : 1'b0;    // Toggles for as long as cs is held
        end
    end

    // Hides the MPEG RAM from the OS RAM scan until the driver has set up the chip
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_cnt           <= '0;
            mpeg_ram_enabled <= 1'b0;
        end else if (reg_wr && !mpeg_ram_enabled) begin
            wr_cnt <= wr_cnt + 1'b1;
            if (wr_cnt == CNT_W'(RAM_EN_WRITES - 1))
                mpeg_ram_enabled <= 1'b1;
        end
    end

    // CPU releases the bus once the cycle has completed
    a_bus_released: assert property (@(posedge clk) disable iff (reset)
        (reg_rd || reg_wr) |=> !access);

endmodule

`default_nettype wire

// ==== logic/dvc_timebase.sv ====
`timescale 1ns/1ps
`default_nettype none

module dvc_timebase #(
    parameter int CLK_DIV = 667
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             timer_restart,
    input  logic [15:0]                      tcnt,
    output logic                             dclk_tick,
    output logic                             timer_tick,
    output logic [dvc_pkg::DCLK_W-1:0]       dclk
);

    localparam int DIV_W   = $clog2(CLK_DIV);
    localparam int TIMER_W = 16 + dvc_pkg::TIMER_FRAC;

    logic [DIV_W-1:0]   div_cnt;
    logic [TIMER_W-1:0] timer_cnt;

    assign dclk_tick = (div_cnt == DIV_W'(CLK_DIV - 1));

    // Match on the last fractional step, so a period is (tcnt+1)*8 DCLK ticks
    assign timer_tick = dclk_tick &&
                        (timer_cnt == {tcnt, {dvc_pkg::TIMER_FRAC{1'b1}}});

    // Prescaler and 45 kHz DCLK
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt <= '0;
            dclk    <= '0;
        end else if (dclk_tick) begin
            div_cnt <= '0;
            dclk    <= dclk + 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || timer_restart) begin
            timer_cnt <= '0;    // TRLD write restarts the interval
        end else if (timer_tick) begin
            timer_cnt <= '0;
        end else if (dclk_tick) begin
            timer_cnt <= timer_cnt + 1'b1;
        end
    end

    // A TCNT lowered below the elapsed count without a restart would wrap
    a_no_missed_match: assert property (@(posedge clk) disable iff (reset)
        dclk_tick && !timer_restart && (timer_cnt == '1) |-> timer_tick);

endmodule

`default_nettype wire

// ==== logic/dvc_registers.sv ====
`timescale 1ns/1ps
`default_nettype none

module dvc_registers (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             reg_rd,
    input  logic                             reg_wr,
    input  logic                             intack,
    input  logic                             vsync,
    input  logic                             dclk_tick,
    input  logic                             timer_tick,
    input  logic                             dma_done,
    input  logic [dvc_pkg::REG_W-1:0]        reg_addr,
    input  logic [dvc_pkg::WORD_W-1:0]       wr_data,
    input  logic [dvc_pkg::DCLK_W-1:0]       dclk,
    output logic                             intreq,
    output logic                             timer_restart,
    output logic                             dma_start_fma,
    output logic                             dma_start_fmv,
    output logic                             xfer_wr,
    output logic [15:0]                      tcnt,
    output logic [dvc_pkg::WORD_W-1:0]       dout
);

    logic [dvc_pkg::WORD_W-1:0] fma_cmd;
    logic [dvc_pkg::WORD_W-1:0] fma_ier;
    logic [dvc_pkg::WORD_W-1:0] fma_isr;
    logic [dvc_pkg::WORD_W-1:0] fma_ivec;
    logic [dvc_pkg::WORD_W-1:0] fmv_ier;
    dvc_pkg::fmv_isr_u          fmv_isr;
    logic [dvc_pkg::WORD_W-1:0] fmv_ivec;
    logic [15:0]                dclk_lo_latch;
    logic                       vsync_q;
    logic                       vsync_rise;
    logic                       fma_irq;
    logic                       fmv_irq;

    assign vsync_rise = vsync && !vsync_q;

    // Command decode, one-cycle strobes
    assign dma_start_fma = reg_wr && (reg_addr == dvc_pkg::FMA_CMD) &&
                           wr_data[dvc_pkg::FMA_DMA_BIT];
    assign dma_start_fmv = reg_wr && (reg_addr == dvc_pkg::FMV_SYSCMD) &&
                           (wr_data == dvc_pkg::FMV_DMA_START);
    assign timer_restart = reg_wr && (reg_addr == dvc_pkg::FMV_TRLD);
    assign xfer_wr       = reg_wr && (reg_addr == dvc_pkg::FMV_XFER);

    assign fma_irq = |(fma_isr & fma_ier);
    assign fmv_irq = |(fmv_isr.raw & fmv_ier);
    assign intreq  = fma_irq || fmv_irq;

    always_ff @(posedge clk) begin
        if (reset) begin
            fma_cmd     <= '0;
            fma_ier     <= '0;
            fma_isr     <= '0;
            fmv_ier     <= '0;
            fmv_isr.raw <= '0;
            tcnt        <= 16'd55;    // About 10 ms per period
            vsync_q     <= 1'b0;
        end else begin
            vsync_q <= vsync;
            if (dma_done)
                fma_cmd[dvc_pkg::FMA_DMA_BIT] <= 1'b0;
            if (reg_wr) begin
                case (reg_addr)
                    dvc_pkg::FMA_CMD:  fma_cmd <= wr_data;
                    dvc_pkg::FMA_IER:  fma_ier <= wr_data;
                    dvc_pkg::FMV_IER:  fmv_ier <= wr_data;
                    dvc_pkg::FMV_TCNT: tcnt    <= wr_data;
                    default: ;
                endcase
            end
            // Status is cleared by reading it
            if (reg_rd && reg_addr == dvc_pkg::FMA_ISR)
                fma_isr <= '0;
            if (reg_rd && reg_addr == dvc_pkg::FMV_ISR)
                fmv_isr.raw <= '0;
            // New events win over a clearing read in the same cycle
            if (vsync_rise)
                fmv_isr.flags.vsync <= 1'b1;
            if (timer_tick) begin
                fmv_isr.flags.tim              <= 1'b1;
                fma_isr[dvc_pkg::FMA_POLL_BIT] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr && reg_addr == dvc_pkg::FMA_IVEC)
            fma_ivec <= wr_data;
        if (reg_wr && reg_addr == dvc_pkg::FMV_IVEC)
            fmv_ivec <= wr_data;
        if (reg_rd && reg_addr == dvc_pkg::FMA_DCLKH)
            dclk_lo_latch <= dclk[15:0];    // Keeps the pair coherent
    end

    always_comb begin
        dout = '0;
        case (reg_addr)
            dvc_pkg::FMA_CMD:   dout = fma_cmd;
            dvc_pkg::FMA_IVEC:  dout = fma_ivec;
            dvc_pkg::FMA_DCLKH: dout = dclk[dvc_pkg::DCLK_W-1:dvc_pkg::DCLK_W-16];
            dvc_pkg::FMA_DCLKL: dout = dclk_lo_latch;
            dvc_pkg::FMA_ISR:   dout = fma_isr;
            dvc_pkg::FMA_IER:   dout = fma_ier;
            dvc_pkg::FMV_IER:   dout = fmv_ier;
            dvc_pkg::FMV_ISR:   dout = fmv_isr.raw;
            dvc_pkg::FMV_TCNT:  dout = tcnt;
            dvc_pkg::FMV_IVEC:  dout = fmv_ivec;
            default: ;
        endcase
        // Vector fetch, byte duplicated for either data strobe
        if (intack) begin
            if (fma_irq)
                dout = {fma_ivec[7:0], fma_ivec[7:0]};
            else
                dout = {fmv_ivec[10:3], fmv_ivec[10:3]};
        end
    end

    // Timer only advances on a DCLK step
    a_timer_on_dclk: assert property (@(posedge clk) disable iff (reset)
        timer_tick |-> dclk_tick);

endmodule

`default_nettype wire

// ==== logic/dvc_dma_stream.sv ====
`timescale 1ns/1ps
`default_nettype none

module dvc_dma_stream (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             dma_start_fma,
    input  logic                             dma_start_fmv,
    input  logic                             xfer_wr,
    input  logic                             ack,
    input  logic                             dtc,
    input  logic                             done_in,
    input  logic [dvc_pkg::WORD_W-1:0]       din,
    output logic                             req,
    output logic                             rdy,
    output logic                             dma_done,
    output logic                             stream_valid,
    output logic                             stream_audio,
    output logic [7:0]                       stream_byte
);

    logic       dma_active;
    logic       dma_audio;      // Routing of the running transfer
    logic       word_valid;
    logic       low_pending;
    logic [7:0] low_byte;

    assign req        = dma_active;
    assign rdy        = dma_active;
    assign dma_done   = done_in && ack;
    assign word_valid = (ack && dtc) || xfer_wr;

    // A start in the same cycle as done takes precedence
    always_ff @(posedge clk) begin
        if (reset) begin
            dma_active <= 1'b0;
            dma_audio  <= 1'b0;
        end else begin
            if (dma_done)
                dma_active <= 1'b0;
            if (dma_start_fma || dma_start_fmv) begin
                dma_active <= 1'b1;
                dma_audio  <= dma_start_fma;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stream_valid <= 1'b0;
            low_pending  <= 1'b0;
        end else begin
            stream_valid <= word_valid || low_pending;
            low_pending  <= word_valid;
        end
    end

    // High byte goes out first, low byte the cycle after
    always_ff @(posedge clk) begin
        if (word_valid) begin
            stream_byte  <= din[15:8];
            low_byte     <= din[7:0];
            stream_audio <= dma_audio;
        end else if (low_pending) begin
            stream_byte <= low_byte;
        end
    end

    a_word_spacing: assert property (@(posedge clk) disable iff (reset)
        word_valid |-> !low_pending);

endmodule

`default_nettype wire

// ==== logic/dvc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dvc_top #(
    parameter int CLK_DIV       = 667,
    parameter int RAM_EN_WRITES = 64
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cs,
    input  logic                             uds,
    input  logic                             lds,
    input  logic                             write_strobe,
    input  logic                             intack,
    input  logic                             ack,
    input  logic                             dtc,
    input  logic                             done_in,
    input  logic                             vsync,
    input  logic [dvc_pkg::ADDR_W-1:0]       address,
    input  logic [dvc_pkg::WORD_W-1:0]       din,
    output logic [dvc_pkg::WORD_W-1:0]       dout,
    output logic                             bus_ack,
    output logic                             intreq,
    output logic                             req,
    output logic                             rdy,
    output logic                             stream_valid,
    output logic                             stream_audio,
    output logic [7:0]                       stream_byte,
    output logic                             mpeg_ram_enabled
);

    logic                       reg_rd;
    logic                       reg_wr;
    logic [dvc_pkg::REG_W-1:0]  reg_addr;
    logic [dvc_pkg::WORD_W-1:0] wr_data;
    logic                       dclk_tick;
    logic                       timer_tick;
    logic                       timer_restart;
    logic [15:0]                tcnt;
    logic [dvc_pkg::DCLK_W-1:0] dclk;
    logic                       dma_start_fma;
    logic                       dma_start_fmv;
    logic                       xfer_wr;
    logic                       dma_done;

    dvc_bus_decoder #(.RAM_EN_WRITES(RAM_EN_WRITES)) u_bus (
        .clk, .reset, .cs, .uds, .lds, .write_strobe, .address, .din,
        .bus_ack, .reg_rd, .reg_wr, .mpeg_ram_enabled, .reg_addr, .wr_data
    );

    dvc_registers u_regs (
        .clk, .reset, .reg_rd, .reg_wr, .intack, .vsync, .dclk_tick, .timer_tick,
        .dma_done, .reg_addr, .wr_data, .dclk, .intreq, .timer_restart,
        .dma_start_fma, .dma_start_fmv, .xfer_wr, .tcnt, .dout
    );

    dvc_timebase #(.CLK_DIV(CLK_DIV)) u_time (
        .clk, .reset, .timer_restart, .tcnt, .dclk_tick, .timer_tick, .dclk
    );

    dvc_dma_stream u_dma (
        .clk, .reset, .dma_start_fma, .dma_start_fmv, .xfer_wr, .ack, .dtc, .done_in,
        .din, .req, .rdy, .dma_done, .stream_valid, .stream_audio, .stream_byte
    );

endmodule

`default_nettype wire

// ==== bench/tb_dvc_tests.svh ====
`ifndef TB_DVC_TESTS_SVH
`define TB_DVC_TESTS_SVH

// Parks the timer far away and masks both units
task automatic silence_interrupts();
    logic [15:0] rd;
    bus_write(dvc_pkg::FMV_TCNT, 16'hffff);
    bus_write(dvc_pkg::FMV_TRLD, 16'h0000);
    bus_write(dvc_pkg::FMA_IER, 16'h0000);
    bus_write(dvc_pkg::FMV_IER, 16'h0000);
    bus_read(dvc_pkg::FMA_ISR, rd);
    bus_read(dvc_pkg::FMV_ISR, rd);
endtask

task automatic test_readback();
    logic [14:0] regs[5];
    logic [15:0] data;
    logic [15:0] rd;
    regs = '{dvc_pkg::FMA_IVEC, dvc_pkg::FMA_IER, dvc_pkg::FMV_IER,
             dvc_pkg::FMV_TCNT, dvc_pkg::FMV_IVEC};
    foreach (regs[i]) begin
        data = random_word();
        bus_write(regs[i], data);
        bus_read(regs[i], rd);
        check_word("readback", data, rd);
    end
    silence_interrupts();
endtask

task automatic test_vsync_irq();
    dvc_pkg::fmv_isr_u vs_flag;
    logic [15:0]       vec;
    logic [15:0]       rd;
    vs_flag.raw = '0;
    vs_flag.flags.vsync = 1'b1;
    vec = random_word();
    bus_write(dvc_pkg::FMV_IVEC, vec);
    bus_write(dvc_pkg::FMV_IER, vs_flag.raw);
    check_word("vsync idle intreq", 0, intreq);
    @(negedge clk);
    vsync = 1'b1;
    @(negedge clk);
    vsync = 1'b0;
    wait_for_intreq("vsync", 20);
    check_vector("vsync vector", {vec[10:3], vec[10:3]});    // FMV vector bits 10..3
    bus_read(dvc_pkg::FMV_ISR, rd);
    check_word("vsync isr first read", vs_flag.raw, rd);
    bus_read(dvc_pkg::FMV_ISR, rd);
    check_word("vsync isr second read", 0, rd);
    bus_write(dvc_pkg::FMV_IER, 16'h0000);
endtask

// Compare of 1 fires after 16 DCLK ticks
task automatic test_timer_irq();
    logic [15:0] vec;
    logic [15:0] rd;
    vec = random_word();
    bus_write(dvc_pkg::FMA_IVEC, vec);
    bus_write(dvc_pkg::FMV_TCNT, 16'd1);
    bus_write(dvc_pkg::FMV_TRLD, 16'd0);
    bus_write(dvc_pkg::FMA_IER, 16'h0001 << dvc_pkg::FMA_POLL_BIT);
    wait_for_intreq("timer", 40 * 8 * CLK_DIV);
    check_vector("timer vector", {vec[7:0], vec[7:0]});
    bus_read(dvc_pkg::FMA_ISR, rd);
    check_word("timer fma poll flag", 1, rd[dvc_pkg::FMA_POLL_BIT]);
    silence_interrupts();
endtask

task automatic test_dclk();
    logic [15:0] hi;
    logic [15:0] lo;
    logic [31:0] first;
    logic [31:0] second;
    bus_read(dvc_pkg::FMA_DCLKH, hi);
    bus_read(dvc_pkg::FMA_DCLKL, lo);
    first = {hi, lo};
    repeat (200) @(negedge clk);
    bus_read(dvc_pkg::FMA_DCLKH, hi);
    bus_read(dvc_pkg::FMA_DCLKL, lo);
    second = {hi, lo};
    checks++;
    if (second <= first) begin
        errors++;
        $display("ERROR dclk: expected above %h, got %h", first, second);
    end
endtask

task automatic test_dma_stream();
    logic [15:0] words[3];
    logic [8:0]  expected[$];
    logic [15:0] xfer;
    logic [15:0] rd;
    stream_seen.delete();
    bus_write(dvc_pkg::FMA_CMD, 16'h8000);
    check_word("dma fma req", 1, req);
    check_word("dma fma rdy", 1, rdy);
    foreach (words[i]) begin
        words[i] = random_word();
        expected.push_back({1'b1, words[i][15:8]});    // High byte leads
        expected.push_back({1'b1, words[i][7:0]});
        dma_word(words[i]);
    end
    dma_finish();
    check_word("dma done req", 0, req);
    check_word("dma done rdy", 0, rdy);
    bus_read(dvc_pkg::FMA_CMD, rd);
    check_word("dma done cmd bit 15", 0, rd[dvc_pkg::FMA_DMA_BIT]);
    xfer = random_word();
    bus_write(dvc_pkg::FMV_SYSCMD, 16'h8000);
    check_word("dma fmv req", 1, req);
    check_word("dma fmv rdy", 1, rdy);
    expected.push_back({1'b0, xfer[15:8]});
    expected.push_back({1'b0, xfer[7:0]});
    bus_write(dvc_pkg::FMV_XFER, xfer);
    dma_finish();
    repeat (3) @(negedge clk);
    check_word("dma byte count", expected.size(), stream_seen.size());
    foreach (expected[i]) begin
        if (i < stream_seen.size())
            check_word("dma stream byte", expected[i], stream_seen[i]);
    end
endtask

task automatic test_ram_enable();
    int tries;
    tries = 0;
    while (write_count < RAM_EN_WRITES && tries < 2 * RAM_EN_WRITES) begin
        check_word("ram enable early", 0, mpeg_ram_enabled);
        bus_write(dvc_pkg::FMA_IVEC, random_word());
        tries++;
    end
    check_word("ram enable after 64 writes", 1, mpeg_ram_enabled);
endtask

`endif

// ==== bench/tb_dvc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dvc;

    localparam int CLK_DIV       = 4;
    localparam int RAM_EN_WRITES = 64;
    localparam int BUS_TIMEOUT   = 20;    // Cycles until bus_ack must show

    logic        clk;
    logic        reset;
    logic        cs;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic        intack;
    logic        ack;
    logic        dtc;
    logic        done_in;
    logic        vsync;
    logic [22:0] address;
    logic [15:0] din;
    logic [15:0] dout;
    logic        bus_ack;
    logic        intreq;
    logic        req;
    logic        rdy;
    logic        stream_valid;
    logic        stream_audio;
    logic [7:0]  stream_byte;
    logic        mpeg_ram_enabled;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          write_count;    // Completed bus writes since reset
    logic [8:0]  stream_seen[$];    // {audio, byte} as seen on the stream

    dvc_top #(.CLK_DIV(CLK_DIV), .RAM_EN_WRITES(RAM_EN_WRITES)) dut (
        .clk, .reset, .cs, .uds, .lds, .write_strobe, .intack, .ack, .dtc,
        .done_in, .vsync, .address, .din, .dout, .bus_ack, .intreq, .req, .rdy,
        .stream_valid, .stream_audio, .stream_byte, .mpeg_ram_enabled
    );

    always #50 clk = ~clk;

    // Byte stream capture
    always @(negedge clk) begin
        if (stream_valid === 1'b1)
            stream_seen.push_back({stream_audio, stream_byte});
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [15:0] random_word();
        logic [15:0] w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);    // One step per bit
            w = {w[14:0], lfsr_state[0]};
        end
        return w;
    endfunction

    task automatic check_word(input string test, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, got %h", test, expected, actual);
        end
    endtask

    // Holds cs through the completing edge, then releases the bus
    task automatic bus_cycle(input logic wr, input logic [14:0] reg_addr,
                             input logic [15:0] data, output logic [15:0] rdata);
        int waited;
        rdata = 'x;
        waited = 0;
        @(negedge clk);
        cs = 1'b1;
        uds = 1'b1;
        lds = 1'b1;
        write_strobe = wr;
        address = 23'(reg_addr);
        din = data;
        @(negedge clk);
        while (bus_ack !== 1'b1 && waited < BUS_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (bus_ack !== 1'b1) begin
            errors++;
            $display("Bus cycle to register %h never saw bus_ack", reg_addr);
        end else begin
            rdata = dout;
            if (wr)
                write_count++;
        end
        @(negedge clk);
        cs = 1'b0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
    endtask

    task automatic bus_write(input logic [14:0] reg_addr, input logic [15:0] data);
        logic [15:0] unused;
        bus_cycle(1'b1, reg_addr, data, unused);
    endtask

    task automatic bus_read(input logic [14:0] reg_addr, output logic [15:0] data);
        bus_cycle(1'b0, reg_addr, 16'h0000, data);
    endtask

    task automatic wait_for_intreq(input string test, input int limit);
        int waited;
        waited = 0;
        while (intreq !== 1'b1 && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (intreq !== 1'b1) begin
            errors++;
            $display("%s: intreq did not rise within %0d cycles", test, limit);
        end
    endtask

    task automatic check_vector(input string test, input logic [15:0] expected);
        @(negedge clk);
        intack = 1'b1;
        @(negedge clk);
        check_word(test, expected, dout);
        intack = 1'b0;
    endtask

    // One DMA word, accepted on the next rising edge
    task automatic dma_word(input logic [15:0] data);
        @(negedge clk);
        ack = 1'b1;
        dtc = 1'b1;
        din = data;
        @(negedge clk);
        ack = 1'b0;
        dtc = 1'b0;
    endtask

    task automatic dma_finish();
        @(negedge clk);
        ack = 1'b1;
        done_in = 1'b1;
        @(negedge clk);
        ack = 1'b0;
        done_in = 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cs = 1'b0;
        uds = 1'b0;
        lds = 1'b0;
        write_strobe = 1'b0;
        intack = 1'b0;
        ack = 1'b0;
        dtc = 1'b0;
        done_in = 1'b0;
        vsync = 1'b0;
        address = '0;
        din = '0;
        lfsr_state = 32'h0be3_e873;
        errors = 0;
        checks = 0;
        write_count = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_readback();
        test_vsync_irq();
        test_timer_irq();
        test_dclk();
        test_dma_stream();
        test_ram_enable();

        $display("tb_dvc: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    `include "tb_dvc_tests.svh"

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+bench
logic/dvc_pkg.sv
logic/dvc_bus_decoder.sv
logic/dvc_timebase.sv
logic/dvc_registers.sv
logic/dvc_dma_stream.sv
logic/dvc_top.sv
bench/tb_dvc.sv
